//--- hw/osdPkg.sv
// ##########################################################
// OSD shared definitions
// ##########################################################
`default_nettype none

package osdPkg;

    // video and host words
    typedef logic [23:0] pixel_t;
    typedef logic [15:0] hostWord_t;

    // bitmap storage, one byte holds eight rows of a column
    typedef logic [11:0] bufAddr_t;
    typedef logic [7:0]  bufByte_t;

    // raster geometry
    typedef logic [21:0] rasterCount_t;
    typedef logic [7:0]  osdCol_t;
    typedef logic [6:0]  osdRow_t;

    localparam int OSD_WIDTH     = 256;
    localparam int OSD_ROWS_LOW  = 64;
    localparam int OSD_ROWS_HIGH = 128;

    // host command codes
    localparam logic [3:0] CMD_ENABLE = 4'h4;
    localparam logic [2:0] CMD_WRITE  = 3'b001;

    // video to output latency in clocks
    localparam int MIX_DELAY = 5;

    typedef enum logic [1:0] {
        idle,
        awaitCommand,
        writeData,
        skipData
    } decState_t;

endpackage

`default_nettype wire

//--- hw/rasterIf.sv
// ##########################################################
// Raster position bus
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

interface rasterIf;
    import osdPkg::*;

    logic         cePix;
    logic         lineStart;
    logic         frameStart;
    rasterCount_t hCount;
    rasterCount_t lineWidth;
    rasterCount_t vCount;
    rasterCount_t frameLines;

    modport source (
        output cePix, lineStart, frameStart, hCount, lineWidth, vCount, frameLines
    );

    modport sink (
        input cePix, lineStart, frameStart, hCount, lineWidth, vCount, frameLines
    );
endinterface

`default_nettype wire

//--- hw/osdCommandDecoder.sv
// ##########################################################
// OSD host command decoder
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module osdCommandDecoder (
    input  wire                     clk_video,
    input  wire                     reset,
    input  wire                     hostSelect,
    input  wire                     hostStrobe,
    input  wire osdPkg::hostWord_t  hostData,
    output logic                    bufWrite,
    output osdPkg::bufAddr_t        bufWrAddr,
    output osdPkg::bufByte_t        bufWrData,
    output logic                    osdEnable,
    output logic                    highRes,
    output logic                    osdStatus
);
    import osdPkg::*;

    decState_t state;
    logic      strobeD;
    logic      strobeEdge;
    logic      enablePending;
    logic      pendingValue;
    bufAddr_t  writePtr;

    assign strobeEdge = hostStrobe & ~strobeD;

    always_ff @(posedge clk_video) begin
        if (reset) begin
            state         <= idle;
            strobeD       <= 1'b0;
            bufWrite      <= 1'b0;
            osdEnable     <= 1'b0;
            highRes       <= 1'b0;
            osdStatus     <= 1'b0;
            enablePending <= 1'b0;
            pendingValue  <= 1'b0;
        end else begin
            strobeD  <= hostStrobe;
            bufWrite <= 1'b0;

            if (!hostSelect) begin
                // end of transfer, a pending enable command now takes effect
                state <= idle;
                if (enablePending) begin
                    osdEnable <= pendingValue;
                end
                enablePending <= 1'b0;
            end else begin
                case (state)
                    idle, awaitCommand: begin
                        state <= awaitCommand;
                        if (strobeEdge) begin
                            state <= skipData;
                            if (hostData[7:4] == CMD_ENABLE) begin
                                enablePending <= 1'b1;
                                pendingValue  <= hostData[0];
                                if (hostData[0]) begin
                                    osdStatus <= 1'b1;
                                end else begin
                                    osdStatus <= 1'b0;
                                    highRes   <= 1'b0;
                                end
                            end else if (hostData[7:5] == CMD_WRITE) begin
                                state <= writeData;
                                if (hostData[3]) begin
                                    highRes <= 1'b1;
                                end
                                // start on a 256 byte boundary
                                writePtr <= bufAddr_t'({hostData[4:0], 8'h00});
                            end
                        end
                    end
                    writeData: begin
                        if (strobeEdge) begin
                            bufWrite  <= 1'b1;
                            bufWrAddr <= writePtr;
                            bufWrData <= hostData[7:0];
                            writePtr  <= writePtr + 1'b1;
                        end
                    end
                    default: begin
                        // words after an enable or unknown command are dropped
                        state <= skipData;
                    end
                endcase
            end
        end
    end
endmodule

`default_nettype wire

//--- hw/osdPixelClock.sv
// ##########################################################
// Pixel clock enable
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module osdPixelClock (
    input  wire  clk_video,
    input  wire  reset,
    input  wire  deIn,
    output logic cePix
);
    import osdPkg::*;

    logic         deD;
    rasterCount_t cnt;
    rasterCount_t scaled;
    rasterCount_t pixSize;
    rasterCount_t pixCnt;

    // active width in units of 512 clocks
    assign scaled = (cnt + 1'b1) >> 9;

    always_ff @(posedge clk_video) begin
        if (reset) begin
            deD     <= 1'b0;
            cnt     <= '0;
            pixSize <= '0;
            pixCnt  <= '0;
            cePix   <= 1'b0;
        end else begin
            deD   <= deIn;
            cnt   <= (deIn && !deD) ? '0 : cnt + 1'b1;
            cePix <= (pixCnt == '0);

            if (pixCnt == pixSize) begin
                pixCnt <= '0;
            end else begin
                pixCnt <= pixCnt + 1'b1;
            end

            // end of line, pick the divider and restart it
            if (deD && !deIn) begin
                pixSize <= (scaled > 1) ? scaled - 1'b1 : '0;
                pixCnt  <= '0;
            end
        end
    end
endmodule

`default_nettype wire

//--- hw/osdRaster.sv
// ##########################################################
// Raster counters
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module osdRaster (
    input  wire      clk_video,
    input  wire      reset,
    input  wire      deIn,
    input  wire      cePix,
    rasterIf.source  raster
);
    import osdPkg::*;

    logic deD;
    logic deRise;
    logic deFall;
    logic frameGap;

    assign deRise = deIn & ~deD;
    assign deFall = ~deIn & deD;

    // a blank of more than four line widths marks a new frame
    assign frameGap = raster.hCount > (raster.lineWidth << 2);

    assign raster.cePix = cePix;

    always_ff @(posedge clk_video) begin
        if (reset) begin
            deD               <= 1'b0;
            raster.lineStart  <= 1'b0;
            raster.frameStart <= 1'b0;
            raster.hCount     <= '0;
            raster.lineWidth  <= '0;
            raster.vCount     <= '0;
            raster.frameLines <= '0;
        end else begin
            deD               <= deIn;
            raster.lineStart  <= deRise;
            raster.frameStart <= deRise & frameGap;

            if (deRise) begin
                raster.hCount <= '0;
            end else if (cePix && !(&raster.hCount)) begin
                raster.hCount <= raster.hCount + 1'b1;
            end

            if (deFall) begin
                raster.lineWidth <= raster.hCount + 1'b1;
            end

            if (deRise) begin
                if (frameGap) begin
                    raster.vCount     <= '0;
                    raster.frameLines <= raster.vCount + 1'b1;
                end else begin
                    raster.vCount <= raster.vCount + 1'b1;
                end
            end
        end
    end
endmodule

`default_nettype wire

//--- hw/osdWindow.sv
// ##########################################################
// Centered OSD window
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module osdWindow (
    input  wire               clk_video,
    input  wire               reset,
    rasterIf.sink             raster,
    input  wire               osdEnable,
    input  wire               highRes,
    output osdPkg::bufAddr_t  rdAddr,
    output logic [2:0]        rdBit,
    output logic              inWindow
);
    import osdPkg::*;

    // clocks from hCount match to the mixer input
    localparam rasterCount_t pipeLead = 22'd4;

    logic         enLatched;
    logic         hiLatched;
    logic         lineStartD;
    logic         vActive;
    logic         hActive;
    osdCol_t      col;
    osdRow_t      row;
    rasterCount_t rowCount;
    rasterCount_t vStart;
    rasterCount_t rowOffset;
    rasterCount_t hStart;

    assign rowCount  = hiLatched ? rasterCount_t'(OSD_ROWS_HIGH) : rasterCount_t'(OSD_ROWS_LOW);
    assign vStart    = (raster.frameLines - rowCount) >> 1;
    assign rowOffset = raster.vCount - vStart;
    assign hStart    = ((raster.lineWidth - rasterCount_t'(OSD_WIDTH)) >> 1) - pipeLead;

    always_ff @(posedge clk_video) begin
        if (reset) begin
            enLatched  <= 1'b0;
            hiLatched  <= 1'b0;
            lineStartD <= 1'b0;
            vActive    <= 1'b0;
            hActive    <= 1'b0;
            col        <= '0;
            row        <= '0;
        end else begin
            lineStartD <= raster.lineStart;

            if (raster.frameStart) begin
                enLatched <= osdEnable;
                hiLatched <= highRes;
            end

            // frame values settle one clock after lineStart
            if (lineStartD) begin
                vActive <= enLatched && (rowOffset < rowCount);
                row     <= osdRow_t'(rowOffset);
            end

            if (raster.cePix) begin
                if (raster.hCount == hStart) begin
                    hActive <= vActive;
                    col     <= '0;
                end else begin
                    if (col == osdCol_t'(OSD_WIDTH - 1)) begin
                        hActive <= 1'b0;
                    end
                    col <= col + 1'b1;
                end
            end
        end
    end

    assign rdAddr   = {row[6:3], col};
    assign rdBit    = row[2:0];
    assign inWindow = hActive;
endmodule

`default_nettype wire

//--- hw/osdBuffer.sv
// ##########################################################
// OSD bitmap memory
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module osdBuffer (
    input  wire               clk_video,
    input  wire               wrEn,
    input  wire osdPkg::bufAddr_t wrAddr,
    input  wire osdPkg::bufByte_t wrData,
    input  wire osdPkg::bufAddr_t rdAddr,
    input  wire [2:0]         rdBit,
    input  wire               inWindow,
    output logic              osdPixel,
    output logic              osdActive
);
    import osdPkg::*;

    localparam int bufDepth = 1 << $bits(bufAddr_t);

    bufByte_t   mem [bufDepth];
    bufByte_t   rdByte;
    logic [2:0] bitD;
    logic       activeD;

    always_ff @(posedge clk_video) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // byte read, then bit select, flag follows both stages
    always_ff @(posedge clk_video) begin
        rdByte    <= mem[rdAddr];
        bitD      <= rdBit;
        activeD   <= inWindow;
        osdPixel  <= rdByte[bitD];
        osdActive <= activeD;
    end
endmodule

`default_nettype wire

//--- hw/osdMixer.sv
// ##########################################################
// OSD colour mixer
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module osdMixer #(
    parameter logic [5:0] osdColor = 6'b111111
) (
    input  wire                   clk_video,
    input  wire osdPkg::pixel_t   din,
    input  wire                   deIn,
    input  wire                   hsIn,
    input  wire                   vsIn,
    input  wire                   osdPixel,
    input  wire                   osdActive,
    output osdPkg::pixel_t        dout,
    output logic                  deOut,
    output logic                  hsOut,
    output logic                  vsOut
);
    import osdPkg::*;

    pixel_t     overlayPix;
    pixel_t     plainD;
    pixel_t     mixD;
    pixel_t     mixOut;
    logic       activeD;
    pixel_t     pixPipe [MIX_DELAY-2];
    logic [2:0] syncPipe [MIX_DELAY];

    // lit bit on top, colour below it, then the dimmed video
    assign overlayPix = {osdPixel, osdColor[5:4], din[23:19],
                         osdPixel, osdColor[3:2], din[15:11],
                         osdPixel, osdColor[1:0], din[7:3]};

    always_ff @(posedge clk_video) begin
        plainD      <= din;
        mixD        <= overlayPix;
        activeD     <= osdActive;
        mixOut      <= activeD ? mixD : plainD;
        pixPipe[0]  <= mixOut;
        syncPipe[0] <= {deIn, hsIn, vsIn};
        for (int i = 1; i < MIX_DELAY - 2; i++) begin
            pixPipe[i] <= pixPipe[i-1];
        end
        for (int i = 1; i < MIX_DELAY; i++) begin
            syncPipe[i] <= syncPipe[i-1];
        end
    end

    assign dout                  = pixPipe[MIX_DELAY-3];
    assign {deOut, hsOut, vsOut} = syncPipe[MIX_DELAY-1];
endmodule

`default_nettype wire

//--- hw/osdOverlay.sv
// ##########################################################
// OSD overlay top
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module osdOverlay #(
    parameter logic [5:0] osdColor = 6'b111111
) (
    input  wire                     clk_video,
    input  wire                     reset,
    input  wire                     hostSelect,
    input  wire                     hostStrobe,
    input  wire osdPkg::hostWord_t  hostData,
    input  wire osdPkg::pixel_t     din,
    input  wire                     deIn,
    input  wire                     hsIn,
    input  wire                     vsIn,
    output osdPkg::pixel_t          dout,
    output logic                    deOut,
    output logic                    hsOut,
    output logic                    vsOut,
    output logic                    osdStatus
);
    import osdPkg::*;

    logic       bufWrite;
    bufAddr_t   bufWrAddr;
    bufByte_t   bufWrData;
    logic       osdEnable;
    logic       highRes;
    logic       cePix;
    bufAddr_t   rdAddr;
    logic [2:0] rdBit;
    logic       inWindow;
    logic       osdPixel;
    logic       osdActive;

    rasterIf rasterBus ();

    osdCommandDecoder u_osdCommandDecoder (
        .clk_video (clk_video),
        .reset     (reset),
        .hostSelect(hostSelect),
        .hostStrobe(hostStrobe),
        .hostData  (hostData),
        .bufWrite  (bufWrite),
        .bufWrAddr (bufWrAddr),
        .bufWrData (bufWrData),
        .osdEnable (osdEnable),
        .highRes   (highRes),
        .osdStatus (osdStatus)
    );

    osdPixelClock u_osdPixelClock (
        .clk_video(clk_video),
        .reset    (reset),
        .deIn     (deIn),
        .cePix    (cePix)
    );

    osdRaster u_osdRaster (
        .clk_video(clk_video),
        .reset    (reset),
        .deIn     (deIn),
        .cePix    (cePix),
        .raster   (rasterBus.source)
    );

    osdWindow u_osdWindow (
        .clk_video(clk_video),
        .reset    (reset),
        .raster   (rasterBus.sink),
        .osdEnable(osdEnable),
        .highRes  (highRes),
        .rdAddr   (rdAddr),
        .rdBit    (rdBit),
        .inWindow (inWindow)
    );

    osdBuffer u_osdBuffer (
        .clk_video(clk_video),
        .wrEn     (bufWrite),
        .wrAddr   (bufWrAddr),
        .wrData   (bufWrData),
        .rdAddr   (rdAddr),
        .rdBit    (rdBit),
        .inWindow (inWindow),
        .osdPixel (osdPixel),
        .osdActive(osdActive)
    );

    osdMixer #(
        .osdColor(osdColor)
    ) u_osdMixer (
        .clk_video(clk_video),
        .din      (din),
        .deIn     (deIn),
        .hsIn     (hsIn),
        .vsIn     (vsIn),
        .osdPixel (osdPixel),
        .osdActive(osdActive),
        .dout     (dout),
        .deOut    (deOut),
        .hsOut    (hsOut),
        .vsOut    (vsOut)
    );
endmodule

`default_nettype wire

//--- tests/osdOverlayTb.sv
// ##########################################################
// OSD overlay testbench
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

module osdOverlayTb;
    import osdPkg::*;

    localparam int hBlank      = 16;
    localparam int modeSync    = 0;
    localparam int modePass    = 1;
    localparam int modeOverlay = 2;
    localparam int modeScaled  = 3;

    logic      clk_video;
    logic      reset;
    logic      hostSelect;
    logic      hostStrobe;
    hostWord_t hostData;
    pixel_t    din;
    logic      deIn;
    logic      hsIn;
    logic      vsIn;
    pixel_t    dout;
    logic      deOut;
    logic      hsOut;
    logic      vsOut;
    logic      osdStatus;

    logic [15:0]  lfsrState = 16'd21531;
    bufByte_t     expMem [4096];
    int           valueErrors = 0;
    int           timeoutErrors = 0;
    int           curMode = modeSync;
    int           curLine = 0;
    int           curPix = -1;
    int           curW = 320;
    int           curH = 80;
    int           curRows = OSD_ROWS_LOW;
    rasterCount_t substCount = '0;
    logic         monitorOn = 1'b0;

    // input history, five entries back lines up with the outputs
    logic [2:0] wrPtr = '0;
    logic [2:0] rdIdx;
    pixel_t     histDin [8];
    logic       histDe [8];
    logic       histHs [8];
    logic       histVs [8];
    int         histMode [8];
    int         histLine [8];
    int         histPix [8];

    osdOverlay u_osdOverlay (
        .clk_video (clk_video),
        .reset     (reset),
        .hostSelect(hostSelect),
        .hostStrobe(hostStrobe),
        .hostData  (hostData),
        .din       (din),
        .deIn      (deIn),
        .hsIn      (hsIn),
        .vsIn      (vsIn),
        .dout      (dout),
        .deOut     (deOut),
        .hsOut     (hsOut),
        .vsOut     (vsOut),
        .osdStatus (osdStatus)
    );

    initial begin
        clk_video = 1'b0;
        forever #2 clk_video = ~clk_video;
    end

    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = {1'b0, lfsrState[15:1]} ^ (outBit ? 16'hB400 : 16'h0000);
        return outBit;
    endfunction

    function automatic logic [23:0] randomBits(input int n);
        logic [23:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[22:0], lfsrBit()};
        end
        return value;
    endfunction

    // clocks per bitmap column for a given active width
    function automatic int pixelPeriod(input int w);
        return (w / 512 > 1) ? w / 512 : 1;
    endfunction

    function automatic pixel_t expectedPixel(input pixel_t v, input logic de,
                                             input int line, input int pix);
        int         vS;
        int         hS;
        int         r;
        int         c;
        logic [2:0] bitIdx;
        logic       lit;
        vS = (curH - curRows) / 2;
        hS = (curW - OSD_WIDTH) / 2;
        if (!de || line < vS || line >= vS + curRows || pix < hS || pix >= hS + OSD_WIDTH) begin
            return v;
        end
        r = line - vS;
        c = pix - hS;
        bitIdx = 3'(r % 8);
        lit = expMem[bufAddr_t'((r / 8) * 256 + c)][bitIdx];
        return {lit, 2'b11, v[23:19], lit, 2'b11, v[15:11], lit, 2'b11, v[7:3]};
    endfunction

    task automatic checkPixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            valueErrors++;
            if (valueErrors <= 20) begin
                $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
            end
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            valueErrors++;
            if (valueErrors <= 20) begin
                $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
            end
        end
    endtask

    task automatic checkCount(input string name, input rasterCount_t got,
                              input rasterCount_t exp);
        if (got !== exp) begin
            valueErrors++;
            if (valueErrors <= 20) begin
                $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
            end
        end
    endtask

    task automatic countScaled(input logic [2:0] idx);
        int           vS;
        rasterCount_t expCount;
        if (histDe[idx] && dout !== histDin[idx]) begin
            substCount = substCount + 1'b1;
        end
        if (histDe[idx] && histPix[idx] == curW - 1) begin
            vS = (curH - curRows) / 2;
            expCount = '0;
            if (histLine[idx] >= vS && histLine[idx] < vS + curRows) begin
                expCount = rasterCount_t'(OSD_WIDTH * pixelPeriod(curW));
            end
            checkCount("substituted pixels", substCount, expCount);
            substCount = '0;
        end
    endtask

    task automatic compareOutputs(input logic [2:0] idx);
        pixel_t expPix;
        checkFlag("deOut", deOut, histDe[idx]);
        checkFlag("hsOut", hsOut, histHs[idx]);
        checkFlag("vsOut", vsOut, histVs[idx]);
        case (histMode[idx])
            modePass: checkPixel("dout", dout, histDin[idx]);
            modeOverlay: begin
                expPix = expectedPixel(histDin[idx], histDe[idx], histLine[idx], histPix[idx]);
                checkPixel("dout", dout, expPix);
            end
            modeScaled: countScaled(idx);
            default: ;
        endcase
    endtask

    always @(negedge clk_video) begin
        histDin[wrPtr]  = din;
        histDe[wrPtr]   = deIn;
        histHs[wrPtr]   = hsIn;
        histVs[wrPtr]   = vsIn;
        histMode[wrPtr] = curMode;
        histLine[wrPtr] = curLine;
        histPix[wrPtr]  = curPix;
        if (monitorOn) begin
            rdIdx = wrPtr - 3'd5;
            compareOutputs(rdIdx);
        end
        wrPtr = wrPtr + 3'd1;
    end

    task automatic strobeWord(input hostWord_t word);
        @(posedge clk_video);
        hostData   <= word;
        hostStrobe <= 1'b1;
        repeat (2) @(posedge clk_video);
        hostStrobe <= 1'b0;
        repeat (2) @(posedge clk_video);
    endtask

    task automatic hostCommand(input hostWord_t cmd);
        @(posedge clk_video);
        hostSelect <= 1'b1;
        strobeWord(cmd);
    endtask

    task automatic hostWrite(input bufByte_t value);
        strobeWord({8'h00, value});
    endtask

    task automatic hostDeselect();
        @(posedge clk_video);
        hostSelect <= 1'b0;
        repeat (2) @(posedge clk_video);
    endtask

    task automatic waitStatus(input logic exp);
        int cycles;
        cycles = 0;
        @(negedge clk_video);
        while (osdStatus !== exp && cycles < 32) begin
            @(negedge clk_video);
            cycles++;
        end
        if (osdStatus !== exp) begin
            timeoutErrors++;
            $display("timeout while waiting for osdStatus to become %0b", exp);
        end
        checkFlag("osdStatus", osdStatus, exp);
    endtask

    task automatic enableOverlay(input logic on);
        hostCommand(on ? 16'h0041 : 16'h0040);
        hostDeselect();
        waitStatus(on);
    endtask

    task automatic writeBitmap(input hostWord_t cmd, input int count, input logic allOnes);
        bufAddr_t addr;
        bufByte_t value;
        addr = bufAddr_t'({cmd[4:0], 8'h00});
        hostCommand(cmd);
        for (int i = 0; i < count; i++) begin
            value = allOnes ? 8'hFF : bufByte_t'(randomBits(8));
            expMem[addr] = value;
            hostWrite(value);
            addr = addr + 1'b1;
        end
        hostDeselect();
    endtask

    task automatic sendFrame(input int w, input int h, input int mode, input logic zeroVideo);
        for (int line = 0; line < h; line++) begin
            for (int p = 0; p < w; p++) begin
                @(posedge clk_video);
                deIn <= 1'b1;
                hsIn <= 1'b0;
                vsIn <= 1'b0;
                din  <= zeroVideo ? pixel_t'(0) : randomBits(24);
                curMode = mode;
                curLine = line;
                curPix  = p;
            end
            for (int b = 0; b < hBlank; b++) begin
                @(posedge clk_video);
                deIn <= 1'b0;
                hsIn <= (b >= 4 && b < 8);
                din  <= '0;
                curPix = -1;
            end
        end
        // long blank so the next line starts a frame
        for (int b = 0; b < 4 * w + 64; b++) begin
            @(posedge clk_video);
            vsIn <= (b >= 8 && b < 24);
        end
    endtask

    // two settling frames, then the checked one
    task automatic checkFrames(input int w, input int h, input int rows, input int mode,
                               input logic zeroVideo);
        curW = w;
        curH = h;
        curRows = rows;
        sendFrame(w, h, modeSync, zeroVideo);
        sendFrame(w, h, modeSync, zeroVideo);
        sendFrame(w, h, mode, zeroVideo);
    endtask

    task automatic testPassthrough();
        @(negedge clk_video);
        checkFlag("osdStatus", osdStatus, 1'b0);
        checkFlag("deOut", deOut, 1'b0);
        checkFlag("hsOut", hsOut, 1'b0);
        checkFlag("vsOut", vsOut, 1'b0);
        curW = 320;
        curH = 80;
        for (int f = 0; f < 3; f++) begin
            sendFrame(320, 80, modePass, 1'b0);
        end
    endtask

    task automatic testBitmapLow();
        writeBitmap(16'h0020, 2048, 1'b0);
        enableOverlay(1'b1);
        checkFrames(320, 80, OSD_ROWS_LOW, modeOverlay, 1'b0);
    endtask

    task automatic testEnableDisable();
        enableOverlay(1'b1);
        enableOverlay(1'b0);
        checkFrames(320, 80, OSD_ROWS_LOW, modePass, 1'b0);
    endtask

    task automatic testHighRes();
        // bit 3 selects 128 rows, start lands at 0xB00
        writeBitmap(16'h002B, 4096, 1'b0);
        enableOverlay(1'b1);
        checkFrames(320, 160, OSD_ROWS_HIGH, modeOverlay, 1'b0);
    endtask

    task automatic testScaling();
        enableOverlay(1'b0);
        writeBitmap(16'h0020, 2048, 1'b1);
        enableOverlay(1'b1);
        checkFrames(1536, 70, OSD_ROWS_LOW, modeScaled, 1'b1);
    endtask

    initial begin
        reset      = 1'b1;
        hostSelect = 1'b0;
        hostStrobe = 1'b0;
        hostData   = '0;
        din        = '0;
        deIn       = 1'b0;
        hsIn       = 1'b0;
        vsIn       = 1'b0;
        repeat (3) @(posedge clk_video);
        reset <= 1'b0;
        repeat (8) @(posedge clk_video);
        monitorOn = 1'b1;

        testPassthrough();
        testBitmapLow();
        testEnableDisable();
        testHighRes();
        testScaling();

        $display("osdOverlayTb: %0d value errors, %0d timeouts", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end
endmodule

`default_nettype wire

//--- sources.f
hw/osdPkg.sv
hw/rasterIf.sv
hw/osdCommandDecoder.sv
hw/osdPixelClock.sv
hw/osdRaster.sv
hw/osdWindow.sv
hw/osdBuffer.sv
hw/osdMixer.sv
hw/osdOverlay.sv
tests/osdOverlayTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the OSD overlay testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

logFile=sim.log

if ! verilator --binary --timing --timescale 1ns/1ns -f sources.f \
        --top-module osdOverlayTb -o osdOverlayTb; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/osdOverlayTb 2>&1 | tee "$logFile"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -qF '*** TEST FAILED ***' "$logFile"; then
    exit 1
fi

exit 0
